// ==== eth_frame_pkg.sv ====
`default_nettype none

// Frame layout and header field values for UDP over IPv4 over Ethernet
package eth_frame_pkg;

    // Widths that carry a meaning in the headers
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] word16_t;

    // Header sizes in bytes
    localparam int MAC_HEADER_BYTES = 14;
    localparam int IP_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES = 8;
    localparam int HEADER_BYTES = MAC_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES;

    // Frame check sequence trails the body
    localparam int FCS_BYTES = 4;

    // MAC header type field, IPv4 payload
    localparam word16_t ETHER_TYPE_IPV4 = 16'h0800;

    // IPv4 header fixed fields
    localparam logic [3:0] IP_VERSION = 4'd4;
    // Header length in 32-bit words, no options
    localparam logic [3:0] IP_IHL = 4'd5;
    // High throughput and reliability requested
    localparam logic [7:0] IP_TOS = 8'h0C;
    localparam logic [7:0] IP_TTL = 8'hFF;
    // Next level protocol is UDP
    localparam logic [7:0] IP_PROTOCOL_UDP = 8'h11;

    // IEEE 802.3 CRC-32, normal form
    localparam logic [31:0] CRC_POLYNOMIAL = 32'h04C11DB7;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== mii_pkg.sv ====
`default_nettype none

// PHY side timing and data definitions
package mii_pkg;

    // One transfer on tx_d
    typedef logic [3:0] nibble_t;

    // 15 preamble nibbles followed by the SFD nibble
    localparam int PREAMBLE_NIBBLES = 16;
    localparam nibble_t PREAMBLE_NIBBLE = 4'b0101;
    localparam nibble_t SFD_NIBBLE = 4'b1101;

    // Interframe gap in tx_clk falls, 20 bytes worth
    localparam int GAP_NIBBLES = 40;

    // Transmit controller states
    typedef enum logic [2:0] {
        POWER_UP,
        READY,
        CHECKSUM_1,
        CHECKSUM_2,
        SEND_PREAMBLE,
        SEND_BODY,
        SEND_FCS,
        GAP
    } tx_state_t;

endpackage

`default_nettype wire

// ==== frame_stream_if.sv ====
`default_nettype none

// Body nibble stream between the controller, the shifter and the CRC
interface frame_stream_if;
    import mii_pkg::*;

    // Start of a new frame, shifter reloads and CRC restarts
    logic load;
    // One step per nibble put on the wire
    logic advance;
    // Body nibble in wire order
    nibble_t nibble;
    // Final body nibble is on nibble
    logic body_last;

    modport ctrl (output load, output advance, input nibble, input body_last);
    modport shifter (input load, input advance, output nibble, output body_last);
    modport crc (input load, input advance, input nibble);

endinterface

`default_nettype wire

// ==== mii_clock.sv ====
`default_nettype none

module mii_clock #(
    parameter int DIVIDER = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic eth_tx_clk,
    output logic eth_ref_clk,
    output logic tx_fall
);

    // Divide ratio must leave room for a high and a low phase
    if (DIVIDER < 2) begin : g_bad_divider
        $error("mii_clock: DIVIDER must be at least 2");
    end

    localparam int COUNT_W = $clog2(DIVIDER);
    localparam int COUNT_MAX = DIVIDER - 1;
    // Reference clock goes high from this count on
    localparam int COUNT_HIGH = DIVIDER / 2;

    logic [COUNT_W-1:0] div_count;
    logic tx_clk_prev;

    // Free running divider, low half first
    always_ff @(posedge clk) begin
        if (reset) begin
            div_count <= '0;
            eth_ref_clk <= 1'b0;
        end else begin
            eth_ref_clk <= (div_count >= COUNT_W'(COUNT_HIGH));
            if (div_count == COUNT_W'(COUNT_MAX)) begin
                div_count <= '0;
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // Previous tx_clk sample, cleared so no fall shows right after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_clk_prev <= 1'b0;
        end else begin
            tx_clk_prev <= eth_tx_clk;
        end
    end

    assign tx_fall = tx_clk_prev && !eth_tx_clk;

endmodule

`default_nettype wire

// ==== frame_builder.sv ====
`default_nettype none

module frame_builder #(
    parameter int DATA_BYTES = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic capture,
    input  logic [8*DATA_BYTES-1:0] data,
    input  eth_frame_pkg::mac_addr_t src_mac,
    input  eth_frame_pkg::mac_addr_t dest_mac,
    input  eth_frame_pkg::ip_addr_t src_ip,
    input  eth_frame_pkg::ip_addr_t dest_ip,
    input  eth_frame_pkg::udp_port_t src_port,
    input  eth_frame_pkg::udp_port_t dest_port,
    output logic [8*eth_frame_pkg::HEADER_BYTES-1:0] header,
    output logic [8*DATA_BYTES-1:0] payload
);
    import eth_frame_pkg::*;

    // Length fields depend only on the payload width
    localparam word16_t IP_TOTAL_LENGTH =
        word16_t'(IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES);
    localparam word16_t UDP_LENGTH = word16_t'(UDP_HEADER_BYTES + DATA_BYTES);

    mac_addr_t src_mac_q;
    mac_addr_t dest_mac_q;
    ip_addr_t src_ip_q;
    ip_addr_t dest_ip_q;
    udp_port_t src_port_q;
    udp_port_t dest_port_q;
    logic [31:0] sum_q;
    logic [16:0] fold_1;
    word16_t fold_2;
    word16_t checksum;

    // Addressing latched on the accepted send edge
    always_ff @(posedge clk) begin
        if (reset) begin
            src_mac_q <= '0;
            dest_mac_q <= '0;
            src_ip_q <= '0;
            dest_ip_q <= '0;
            src_port_q <= '0;
            dest_port_q <= '0;
        end else if (capture) begin
            src_mac_q <= src_mac;
            dest_mac_q <= dest_mac;
            src_ip_q <= src_ip;
            dest_ip_q <= dest_ip;
            src_port_q <= src_port;
            dest_port_q <= dest_port;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            payload <= data;
        end
    end

    // First checksum step, sum of the IPv4 header words
    // Identification, flags and offset words are zero and drop out
    always_ff @(posedge clk) begin
        sum_q <= 32'({IP_VERSION, IP_IHL, IP_TOS}) + 32'(IP_TOTAL_LENGTH)
            + 32'({IP_TTL, IP_PROTOCOL_UDP})
            + 32'(src_ip_q[31:16]) + 32'(src_ip_q[15:0])
            + 32'(dest_ip_q[31:16]) + 32'(dest_ip_q[15:0]);
    end

    // Second step, end-around carry twice then ones complement
    assign fold_1 = {1'b0, sum_q[31:16]} + {1'b0, sum_q[15:0]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};
    assign checksum = ~fold_2;

    // First header byte sits in the top bits
    assign header = {
        dest_mac_q, src_mac_q, ETHER_TYPE_IPV4,
        IP_VERSION, IP_IHL, IP_TOS, IP_TOTAL_LENGTH,
        32'h0,
        IP_TTL, IP_PROTOCOL_UDP, checksum,
        src_ip_q, dest_ip_q,
        src_port_q, dest_port_q, UDP_LENGTH, 16'h0
    };

endmodule

`default_nettype wire

// ==== frame_shifter.sv ====
`default_nettype none

module frame_shifter #(
    parameter int DATA_BYTES = 8
) (
    input  logic clk,
    input  logic reset,
    frame_stream_if.shifter stream,
    input  logic [8*eth_frame_pkg::HEADER_BYTES-1:0] header,
    input  logic [8*DATA_BYTES-1:0] payload
);
    import eth_frame_pkg::*;

    localparam int BODY_BYTES = HEADER_BYTES + DATA_BYTES;
    localparam int BODY_BITS = 8 * BODY_BYTES;
    localparam int BODY_NIBBLES = 2 * BODY_BYTES;
    localparam int COUNT_W = $clog2(BODY_NIBBLES);

    logic [BODY_BITS-1:0] body_q;
    logic [COUNT_W-1:0] count_q;
    logic step;

    // Stop on the last nibble, FCS steps leave the body alone
    assign step = stream.advance && !stream.body_last;

    // Nibble position within the body
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (stream.load) begin
            count_q <= '0;
        end else if (step) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Current byte always at the top, shifted once both nibbles are out
    always_ff @(posedge clk) begin
        if (stream.load) begin
            body_q <= {header, payload};
        end else if (step && count_q[0]) begin
            body_q <= {body_q[BODY_BITS-9:0], 8'h00};
        end
    end

    // Low nibble first, then high nibble
    assign stream.nibble = count_q[0] ? body_q[BODY_BITS-1 -: 4] : body_q[BODY_BITS-5 -: 4];
    assign stream.body_last = (count_q == COUNT_W'(BODY_NIBBLES - 1));

endmodule

`default_nettype wire

// ==== fcs_crc32.sv ====
`default_nettype none

module fcs_crc32 (
    input  logic clk,
    input  logic reset,
    frame_stream_if.crc stream,
    input  logic fcs_shift,
    output mii_pkg::nibble_t fcs_nibble
);
    import eth_frame_pkg::*;
    import mii_pkg::*;

    logic [31:0] crc_q;

    // Four serial CRC steps, data bit 0 goes in first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input nibble_t d);
        logic [31:0] c;
        c = crc;
        for (int j = 0; j < 4; j++) begin
            c = {c[30:0], 1'b0} ^ ((d[j] ^ c[31]) ? CRC_POLYNOMIAL : 32'h0);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            crc_q <= CRC_INIT;
        end else if (stream.load) begin
            crc_q <= CRC_INIT;
        end else if (fcs_shift) begin
            // Next FCS nibble moves to the top
            crc_q <= {crc_q[27:0], 4'h0};
        end else if (stream.advance) begin
            crc_q <= crc_step(crc_q, stream.nibble);
        end
    end

    // Bit 31 leaves first on tx_d[0], so each nibble is reversed
    assign fcs_nibble = ~{crc_q[28], crc_q[29], crc_q[30], crc_q[31]};

endmodule

`default_nettype wire

// ==== tx_control.sv ====
`default_nettype none

module tx_control #(
    parameter int POWER_UP_CYCLES = 17_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic send,
    input  logic tx_fall,
    input  mii_pkg::nibble_t fcs_nibble,
    frame_stream_if.ctrl stream,
    output logic capture,
    output logic fcs_shift,
    output logic ready,
    output logic eth_rstn,
    output logic eth_tx_en,
    output mii_pkg::nibble_t eth_tx_d
);
    import eth_frame_pkg::*;
    import mii_pkg::*;

    if (POWER_UP_CYCLES < 0) begin : g_bad_power_up
        $error("tx_control: POWER_UP_CYCLES must not be negative");
    end

    // One counter serves power-up, preamble, FCS and gap
    localparam int COUNT_MAX = (POWER_UP_CYCLES > GAP_NIBBLES) ? POWER_UP_CYCLES : GAP_NIBBLES;
    localparam int COUNT_W = $clog2(COUNT_MAX + 1);
    localparam int FCS_NIBBLES = 2 * FCS_BYTES;

    tx_state_t state;
    logic [COUNT_W-1:0] count;
    logic send_prev;
    logic advance;

    assign ready = (state == READY);
    // Rising edge of send, only taken while idle
    assign capture = ready && send && !send_prev;

    // Frame goes into the shifter once the checksum has settled
    assign stream.load = (state == CHECKSUM_2);
    assign advance = tx_fall && (state == SEND_BODY || state == SEND_FCS);
    assign stream.advance = advance;
    assign fcs_shift = advance && (state == SEND_FCS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= POWER_UP;
            count <= '0;
            // Starts high so a send held through reset is not an edge
            send_prev <= 1'b1;
            eth_rstn <= 1'b0;
            eth_tx_en <= 1'b0;
            eth_tx_d <= '0;
        end else begin
            send_prev <= send;
            eth_rstn <= 1'b1;
            case (state)
                // PHY needs time after its reset is released
                POWER_UP: begin
                    if (count == COUNT_W'(POWER_UP_CYCLES)) begin
                        count <= '0;
                        state <= READY;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                READY: begin
                    if (capture) begin
                        count <= '0;
                        state <= CHECKSUM_1;
                    end
                end
                CHECKSUM_1: state <= CHECKSUM_2;
                CHECKSUM_2: state <= SEND_PREAMBLE;
                SEND_PREAMBLE: begin
                    if (tx_fall) begin
                        eth_tx_en <= 1'b1;
                        if (count == COUNT_W'(PREAMBLE_NIBBLES - 1)) begin
                            eth_tx_d <= SFD_NIBBLE;
                            count <= '0;
                            state <= SEND_BODY;
                        end else begin
                            eth_tx_d <= PREAMBLE_NIBBLE;
                            count <= count + 1'b1;
                        end
                    end
                end
                // Shifter length decides when the body ends
                SEND_BODY: begin
                    if (tx_fall) begin
                        eth_tx_d <= stream.nibble;
                        if (stream.body_last) begin
                            state <= SEND_FCS;
                        end
                    end
                end
                SEND_FCS: begin
                    if (tx_fall) begin
                        eth_tx_d <= fcs_nibble;
                        if (count == COUNT_W'(FCS_NIBBLES - 1)) begin
                            count <= '0;
                            state <= GAP;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                // First fall drops the pins, then the gap is counted
                GAP: begin
                    if (tx_fall) begin
                        eth_tx_en <= 1'b0;
                        eth_tx_d <= '0;
                        if (count == COUNT_W'(GAP_NIBBLES)) begin
                            count <= '0;
                            state <= READY;
                        end else begin
                            count <= count + 1'b1;
                        end
                    end
                end
                default: state <= POWER_UP;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== udp_eth_tx.sv ====
`default_nettype none

module udp_eth_tx #(
    parameter int DATA_BYTES = 8,
    parameter int DIVIDER = 4,
    parameter int POWER_UP_CYCLES = 17_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic send,
    input  logic [8*DATA_BYTES-1:0] data,
    input  eth_frame_pkg::mac_addr_t src_mac,
    input  eth_frame_pkg::mac_addr_t dest_mac,
    input  eth_frame_pkg::ip_addr_t src_ip,
    input  eth_frame_pkg::ip_addr_t dest_ip,
    input  eth_frame_pkg::udp_port_t src_port,
    input  eth_frame_pkg::udp_port_t dest_port,
    input  logic eth_tx_clk,
    output logic ready,
    output logic eth_ref_clk,
    output logic eth_rstn,
    output logic eth_tx_en,
    output mii_pkg::nibble_t eth_tx_d
);
    import eth_frame_pkg::*;
    import mii_pkg::*;

    // Payload must fit a 576 byte datagram with a full IPv4 header
    if (DATA_BYTES < 1 || DATA_BYTES > 508) begin : g_bad_data_bytes
        $error("udp_eth_tx: DATA_BYTES must be in 1 to 508");
    end

    logic tx_fall;
    logic capture;
    logic fcs_shift;
    logic [8*HEADER_BYTES-1:0] header;
    logic [8*DATA_BYTES-1:0] payload;
    nibble_t fcs_nibble;

    frame_stream_if stream ();

    mii_clock #(.DIVIDER(DIVIDER)) i_mii_clock (
        .clk(clk),
        .reset(reset),
        .eth_tx_clk(eth_tx_clk),
        .eth_ref_clk(eth_ref_clk),
        .tx_fall(tx_fall)
    );

    frame_builder #(.DATA_BYTES(DATA_BYTES)) i_frame_builder (
        .clk(clk),
        .reset(reset),
        .capture(capture),
        .data(data),
        .src_mac(src_mac),
        .dest_mac(dest_mac),
        .src_ip(src_ip),
        .dest_ip(dest_ip),
        .src_port(src_port),
        .dest_port(dest_port),
        .header(header),
        .payload(payload)
    );

    frame_shifter #(.DATA_BYTES(DATA_BYTES)) i_frame_shifter (
        .clk(clk),
        .reset(reset),
        .stream(stream.shifter),
        .header(header),
        .payload(payload)
    );

    fcs_crc32 i_fcs_crc32 (
        .clk(clk),
        .reset(reset),
        .stream(stream.crc),
        .fcs_shift(fcs_shift),
        .fcs_nibble(fcs_nibble)
    );

    tx_control #(.POWER_UP_CYCLES(POWER_UP_CYCLES)) i_tx_control (
        .clk(clk),
        .reset(reset),
        .send(send),
        .tx_fall(tx_fall),
        .fcs_nibble(fcs_nibble),
        .stream(stream.ctrl),
        .capture(capture),
        .fcs_shift(fcs_shift),
        .ready(ready),
        .eth_rstn(eth_rstn),
        .eth_tx_en(eth_tx_en),
        .eth_tx_d(eth_tx_d)
    );

endmodule

`default_nettype wire

// ==== udp_eth_tx_checker.sv ====
`default_nettype none

module udp_eth_tx_checker (
    input  logic clk,
    input  logic reset,
    input  logic ready,
    input  logic eth_rstn,
    input  logic eth_tx_en,
    input  mii_pkg::nibble_t eth_tx_d
);

    // Idle and transmitting are exclusive
    a_ready_not_tx: assert property (@(posedge clk) disable iff (reset)
        !(ready && eth_tx_en))
        else $error("ready and eth_tx_en high in the same cycle");

    // PHY reset follows the system reset one cycle later
    a_rstn_in_reset: assert property (@(posedge clk) reset |=> !eth_rstn)
        else $error("eth_rstn high while reset is high");

    // Data lines quiet outside a frame
    a_tx_d_idle: assert property (@(posedge clk) disable iff (reset)
        !eth_tx_en |-> eth_tx_d == 4'h0)
        else $error("eth_tx_d not zero while eth_tx_en is low");

endmodule

bind udp_eth_tx udp_eth_tx_checker i_udp_eth_tx_checker (
    .clk(clk),
    .reset(reset),
    .ready(ready),
    .eth_rstn(eth_rstn),
    .eth_tx_en(eth_tx_en),
    .eth_tx_d(eth_tx_d)
);

`default_nettype wire

// ==== udp_eth_tx_tb.sv ====
`default_nettype none

module udp_eth_tx_tb;
    import eth_frame_pkg::*;
    import mii_pkg::*;

    localparam int DATA_BYTES = 8;
    localparam int DIVIDER = 4;
    localparam int POWER_UP_CYCLES = 20;
    localparam int NUM_ENTRIES = 5;
    localparam int BODY_BYTES = HEADER_BYTES + DATA_BYTES;
    localparam int FRAME_NIBBLES = PREAMBLE_NIBBLES + 2 * BODY_BYTES + 2 * FCS_BYTES;
    // Reflected 802.3 polynomial for LSB first arithmetic
    localparam logic [31:0] CRC_REFLECTED = 32'hEDB8_8320;
    localparam int FRAME_TIMEOUT = 1000;
    localparam int GAP_TIMEOUT = 300;
    localparam int WATCHDOG_CYCLES = 20000;

    logic clk;
    logic reset;
    logic send;
    logic [8*DATA_BYTES-1:0] data;
    mac_addr_t src_mac;
    mac_addr_t dest_mac;
    ip_addr_t src_ip;
    ip_addr_t dest_ip;
    udp_port_t src_port;
    udp_port_t dest_port;
    logic eth_tx_clk;
    logic ready;
    logic eth_ref_clk;
    logic eth_rstn;
    logic eth_tx_en;
    nibble_t eth_tx_d;

    // Stimulus table, one frame per entry
    mac_addr_t tbl_src_mac [NUM_ENTRIES];
    mac_addr_t tbl_dest_mac [NUM_ENTRIES];
    ip_addr_t tbl_src_ip [NUM_ENTRIES];
    ip_addr_t tbl_dest_ip [NUM_ENTRIES];
    udp_port_t tbl_src_port [NUM_ENTRIES];
    udp_port_t tbl_dest_port [NUM_ENTRIES];
    logic [8*DATA_BYTES-1:0] tbl_data [NUM_ENTRIES];
    word16_t tbl_checksum [NUM_ENTRIES];
    // Send kept high through the frame
    logic tbl_hold [NUM_ENTRIES];
    // Extra send pulses while busy
    logic tbl_pulses [NUM_ENTRIES];

    nibble_t rx_q [$];
    nibble_t exp_q [$];
    logic [7:0] body_q [$];
    logic rx_prev_clk = 1'b0;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int failed_count = 0;
    integer seed = 32'hc0c3686b;
    int errors_before;

    udp_eth_tx #(
        .DATA_BYTES(DATA_BYTES),
        .DIVIDER(DIVIDER),
        .POWER_UP_CYCLES(POWER_UP_CYCLES)
    ) i_udp_eth_tx (
        .clk(clk),
        .reset(reset),
        .send(send),
        .data(data),
        .src_mac(src_mac),
        .dest_mac(dest_mac),
        .src_ip(src_ip),
        .dest_ip(dest_ip),
        .src_port(src_port),
        .dest_port(dest_port),
        .eth_tx_clk(eth_tx_clk),
        .ready(ready),
        .eth_ref_clk(eth_ref_clk),
        .eth_rstn(eth_rstn),
        .eth_tx_en(eth_tx_en),
        .eth_tx_d(eth_tx_d)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // PHY returns the reference clock as tx_clk
    initial begin
        eth_tx_clk = 1'b0;
        forever begin
            @(posedge clk);
            eth_tx_clk <= eth_ref_clk;
        end
    end

    // PHY side sampling on rising tx_clk, mid nibble
    always @(negedge clk) begin
        if (!rx_prev_clk && eth_tx_clk && eth_tx_en) begin
            rx_q.push_back(eth_tx_d);
        end
        rx_prev_clk <= eth_tx_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Returns on the negedge where the pin first shows the level
    task automatic wait_pin(input string pin, input logic level, input int limit);
        int cycles;
        logic value;
        cycles = 0;
        @(negedge clk);
        value = (pin == "ready") ? ready : eth_tx_en;
        while (value !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
            value = (pin == "ready") ? ready : eth_tx_en;
        end
        if (value !== level) begin
            error_count++;
            $display("timeout: %s did not go to %0d within %0d cycles", pin, level, limit);
        end
    endtask

    // Starts on the negedge where eth_tx_en was first seen low
    // Each loop pass sees the tx_clk level the DUT takes on the next edge
    task automatic measure_gap();
        int falls;
        int cycles;
        logic prev;
        falls = 0;
        cycles = 0;
        prev = 1'b0;
        while (!ready && cycles < GAP_TIMEOUT) begin
            if (prev && !eth_tx_clk) begin
                falls++;
            end
            prev = eth_tx_clk;
            @(negedge clk);
            cycles++;
        end
        if (!ready) begin
            error_count++;
            $display("timeout: ready did not return within %0d cycles of the gap", GAP_TIMEOUT);
        end else begin
            compare_value("eth_tx_clk_falls_in_gap", 32'(falls), 32'(GAP_NIBBLES));
        end
    endtask

    // Field bytes go out most significant first
    task automatic push_field(input logic [63:0] value, input int bytes);
        for (int k = bytes - 1; k >= 0; k--) begin
            body_q.push_back(value[8*k +: 8]);
        end
    endtask

    task automatic build_expected(input int idx);
        logic [31:0] crc;
        body_q.delete();
        exp_q.delete();
        push_field(64'(tbl_dest_mac[idx]), 6);
        push_field(64'(tbl_src_mac[idx]), 6);
        push_field(64'(ETHER_TYPE_IPV4), 2);
        push_field(64'({IP_VERSION, IP_IHL, IP_TOS}), 2);
        push_field(64'(IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES), 2);
        // Identification, flags and fragment offset
        push_field(64'(0), 4);
        push_field(64'({IP_TTL, IP_PROTOCOL_UDP}), 2);
        push_field(64'(tbl_checksum[idx]), 2);
        push_field(64'(tbl_src_ip[idx]), 4);
        push_field(64'(tbl_dest_ip[idx]), 4);
        push_field(64'(tbl_src_port[idx]), 2);
        push_field(64'(tbl_dest_port[idx]), 2);
        push_field(64'(UDP_HEADER_BYTES + DATA_BYTES), 2);
        // UDP checksum unused
        push_field(64'(0), 2);
        push_field(64'(tbl_data[idx]), DATA_BYTES);
        for (int i = 0; i < PREAMBLE_NIBBLES - 1; i++) begin
            exp_q.push_back(PREAMBLE_NIBBLE);
        end
        exp_q.push_back(SFD_NIBBLE);
        // Low nibble first on the wire, CRC over the same bytes
        crc = CRC_INIT;
        foreach (body_q[i]) begin
            exp_q.push_back(body_q[i][3:0]);
            exp_q.push_back(body_q[i][7:4]);
            crc = crc ^ 32'(body_q[i]);
            for (int b = 0; b < 8; b++) begin
                crc = crc[0] ? ((crc >> 1) ^ CRC_REFLECTED) : (crc >> 1);
            end
        end
        crc = ~crc;
        for (int k = 0; k < 2 * FCS_BYTES; k++) begin
            exp_q.push_back(crc[4*k +: 4]);
        end
    endtask

    function automatic logic [7:0] rx_byte(input int j);
        return {rx_q[PREAMBLE_NIBBLES + 2*j + 1], rx_q[PREAMBLE_NIBBLES + 2*j]};
    endfunction

    task automatic verify_frame(input int idx);
        int n;
        logic [31:0] sum;
        build_expected(idx);
        compare_value("nibble_count", 32'(rx_q.size()), 32'(FRAME_NIBBLES));
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            compare_value($sformatf("eth_tx_d[%0d]", i), 32'(rx_q[i]), 32'(exp_q[i]));
        end
        if (rx_q.size() >= PREAMBLE_NIBBLES + 2 * (MAC_HEADER_BYTES + IP_HEADER_BYTES)) begin
            // Checksum field sits 10 bytes into the IPv4 header
            compare_value("ipv4_checksum",
                32'({rx_byte(MAC_HEADER_BYTES + 10), rx_byte(MAC_HEADER_BYTES + 11)}),
                32'(tbl_checksum[idx]));
            sum = 32'h0;
            for (int j = MAC_HEADER_BYTES; j < MAC_HEADER_BYTES + IP_HEADER_BYTES; j += 2) begin
                sum = sum + 32'({rx_byte(j), rx_byte(j + 1)});
            end
            sum = 32'(sum[31:16]) + 32'(sum[15:0]);
            sum = 32'(sum[31:16]) + 32'(sum[15:0]);
            compare_value("ipv4_header_sum", 32'(sum[15:0]), 32'hFFFF);
        end
    endtask

    // No frame may start while idle
    task automatic expect_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (eth_tx_en !== 1'b0 || ready !== 1'b1) begin
                compare_value("eth_tx_en", 32'(eth_tx_en), 32'h0);
                compare_value("ready", 32'(ready), 32'h1);
                break;
            end
        end
        compare_value("captured_nibbles", 32'(rx_q.size()), 32'h0);
    endtask

    // Reference clock is high for the second half of each divider period
    task automatic check_ref_clk(input int periods);
        int high_count;
        int rise_count;
        logic prev;
        high_count = 0;
        rise_count = 0;
        @(negedge clk);
        prev = eth_ref_clk;
        for (int i = 0; i < periods * DIVIDER; i++) begin
            @(negedge clk);
            if (eth_ref_clk) begin
                high_count++;
            end
            if (!prev && eth_ref_clk) begin
                rise_count++;
            end
            prev = eth_ref_clk;
        end
        compare_value("eth_ref_clk_high_cycles", 32'(high_count),
                      32'(periods * (DIVIDER - DIVIDER / 2)));
        compare_value("eth_ref_clk_rises", 32'(rise_count), 32'(periods));
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %0s: ok", name);
        end else begin
            failed_count++;
            $display("test %0s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic run_entry(input int idx);
        int errors_at_start;
        errors_at_start = error_count;
        rx_q.delete();
        @(posedge clk);
        send <= 1'b0;
        data <= tbl_data[idx];
        src_mac <= tbl_src_mac[idx];
        dest_mac <= tbl_dest_mac[idx];
        src_ip <= tbl_src_ip[idx];
        dest_ip <= tbl_dest_ip[idx];
        src_port <= tbl_src_port[idx];
        dest_port <= tbl_dest_port[idx];
        @(posedge clk);
        send <= 1'b1;
        wait_pin("ready", 1'b0, 10);
        if (!tbl_hold[idx]) begin
            @(posedge clk);
            send <= 1'b0;
        end
        if (tbl_pulses[idx]) begin
            for (int p = 0; p < 4; p++) begin
                repeat (3) @(posedge clk);
                send <= 1'b1;
                repeat (3) @(posedge clk);
                send <= 1'b0;
            end
        end
        wait_pin("eth_tx_en", 1'b1, 100);
        wait_pin("eth_tx_en", 1'b0, FRAME_TIMEOUT);
        measure_gap();
        verify_frame(idx);
        if (tbl_hold[idx] || tbl_pulses[idx]) begin
            rx_q.delete();
            expect_idle(300);
        end
        finish_test($sformatf("entry %0d", idx), errors_at_start);
    endtask

    // Checksums worked out by hand from the IPv4 header words
    task automatic fill_table();
        tbl_src_mac = '{48'h02_00_00_00_00_01, 48'h02_1A_2B_3C_4D_5E, 48'h02_AA_BB_CC_DD_EE,
                        48'h0, 48'h0E_0F_10_11_12_13};
        tbl_dest_mac = '{48'hFF_FF_FF_FF_FF_FF, 48'h00_11_22_33_44_55, 48'h01_00_5E_00_00_01,
                         48'h0, 48'h0E_0F_10_11_12_14};
        tbl_src_ip = '{32'hC0A8_010A, 32'h0A00_0001, 32'hAC10_FE01, 32'h0, 32'hC0A8_0064};
        tbl_dest_ip = '{32'hC0A8_01FF, 32'h0A00_0002, 32'hFFFF_FFFF, 32'h0, 32'hC0A8_0001};
        tbl_src_port = '{16'h04D2, 16'h8000, 16'hFFFF, 16'h0000, 16'h1F90};
        tbl_dest_port = '{16'h162E, 16'h0035, 16'h0001, 16'h0000, 16'h1F91};
        tbl_checksum = '{16'h3763, 16'hA7BA, 16'h11AB, 16'hBBBD, 16'h3A07};
        tbl_hold = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        tbl_pulses = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
        tbl_data[0] = 64'h0123_4567_89AB_CDEF;
        tbl_data[1] = 64'h4865_6C6C_6F21_0A00;
        for (int i = 2; i < NUM_ENTRIES; i++) begin
            tbl_data[i] = {$random(seed), $random(seed)};
        end
    endtask

    initial begin
        reset = 1'b1;
        send = 1'b0;
        data = '0;
        src_mac = '0;
        dest_mac = '0;
        src_ip = '0;
        dest_ip = '0;
        src_port = '0;
        dest_port = '0;
        fill_table();
        errors_before = error_count;
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare_value("ready", 32'(ready), 32'h0);
        compare_value("eth_tx_en", 32'(eth_tx_en), 32'h0);
        compare_value("eth_tx_d", 32'(eth_tx_d), 32'h0);
        compare_value("eth_rstn", 32'(eth_rstn), 32'h0);
        compare_value("eth_ref_clk", 32'(eth_ref_clk), 32'h0);
        @(posedge clk);
        reset <= 1'b0;
        // PHY reset is released one cycle after the system reset
        @(negedge clk);
        compare_value("eth_rstn", 32'(eth_rstn), 32'h0);
        @(negedge clk);
        compare_value("eth_rstn", 32'(eth_rstn), 32'h1);
        wait_pin("ready", 1'b1, POWER_UP_CYCLES + 20);
        compare_value("captured_nibbles", 32'(rx_q.size()), 32'h0);
        expect_idle(100);
        check_ref_clk(8);
        finish_test("reset and power-up", errors_before);
        // Entries follow each other as soon as ready returns
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            run_entry(idx);
        end
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 test_count, failed_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
eth_frame_pkg.sv
mii_pkg.sv
frame_stream_if.sv
mii_clock.sv
frame_builder.sv
frame_shifter.sv
fcs_crc32.sv
tx_control.sv
udp_eth_tx.sv
udp_eth_tx_checker.sv
udp_eth_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= udp_eth_tx_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
